/* include/gb_debug_defines.svh */
`ifndef GB_DEBUG_DEFINES_SVH
`define GB_DEBUG_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Front panel buttons
////////////////////////////////////////////////////////////////////////////

// Step, continue, bp toggle, bp set
`define GB_N_BUTTONS 4

`define GB_TICK_DIV 4          // Clocks per debounce sample
`define GB_DEBOUNCE_TICKS 3    // Equal samples to accept a level

////////////////////////////////////////////////////////////////////////////
// Debug text overlay
////////////////////////////////////////////////////////////////////////////

`define GB_TEXT_COLS 80        // Cols 0-79
`define GB_TEXT_ROWS 30        // Rows 0-29

`endif

/* hw/gb_debug_pkg.sv */
`include "gb_debug_defines.svh"

package gb_debug_pkg;

  typedef logic [15:0] addr_t;                     // CPU address, pc and bp
  typedef logic [`GB_N_BUTTONS-1:0] button_mask_t; // One bit per button
  typedef logic [1:0] button_idx_t;                // Button index = event code

  // Event codes, one per button
  localparam button_idx_t EV_STEP      = 2'd0;
  localparam button_idx_t EV_CONTINUE  = 2'd1;
  localparam button_idx_t EV_BP_TOGGLE = 2'd2;
  localparam button_idx_t EV_BP_SET    = 2'd3;   // Bp <= current pc

  // Text overlay
  typedef logic [6:0] char_t;   // 7-bit ASCII
  typedef logic [6:0] col_t;
  typedef logic [4:0] row_t;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_REQ,           // Req up, waiting for ack
    ARB_WAIT_ACK_LOW   // Req down, waiting for ack to drop
  } arb_state_e;

  typedef enum logic [1:0] {
    CTRL_HALTED,
    CTRL_STEP,   // Single run cycle
    CTRL_RUN,
    CTRL_ACK     // Halted, command still in flight
  } ctrl_state_e;

endpackage

/* hw/button_sync.sv */
`include "gb_debug_defines.svh"

module button_sync (
  input  logic                       clk,
  input  logic                       reset,
  input  gb_debug_pkg::button_mask_t button_raw,
  output gb_debug_pkg::button_mask_t sync_level,
  output logic                       sample_tick
);

  localparam int DIV_W = $clog2(`GB_TICK_DIV);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`GB_TICK_DIV - 1);

  gb_debug_pkg::button_mask_t meta;   // First stage, may go metastable
  logic [DIV_W-1:0]           div_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // Two-flop synchronizer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      meta       <= '0;
      sync_level <= '0;
    end else begin
      meta       <= button_raw;
      sync_level <= meta;   // 2 cycles after the switch
    end
  end

  // Prescaler for the debounce sample tick
  always_ff @(posedge clk) begin
    if (reset) begin
      div_cnt     <= '0;
      sample_tick <= 1'b0;
    end else begin
      sample_tick <= (div_cnt == DIV_LAST);
      if (div_cnt == DIV_LAST) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // Debouncers count ticks, so a tick is one clock wide
  tick_single_cycle: assert property (@(posedge clk) disable iff (reset)
    sample_tick |=> !sample_tick)
    else $error("sample_tick held high for two cycles");

endmodule

/* hw/button.sv */
`include "gb_debug_defines.svh"

module button (
  input  logic clk,
  input  logic reset,
  input  logic level,         // Synchronized switch
  input  logic sample_tick,
  output logic pressed,       // One-cycle pulse on accepted press
  output logic pressed_disp   // Debounced level, for the LED
);

  localparam int CNT_W = $clog2(`GB_DEBOUNCE_TICKS + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`GB_DEBOUNCE_TICKS - 1);

  logic [CNT_W-1:0] diff_cnt;   // Consecutive samples unlike the accepted level

  ////////////////////////////////////////////////////////////////////////////
  // Debounce
  ////////////////////////////////////////////////////////////////////////////

  // pressed_disp doubles as the accepted level
  always_ff @(posedge clk) begin
    if (reset) begin
      diff_cnt     <= '0;
      pressed_disp <= 1'b0;
      pressed      <= 1'b0;
    end else begin
      pressed <= 1'b0;   // Default, pulse only
      if (sample_tick) begin
        if (level != pressed_disp) begin
          if (diff_cnt == CNT_LAST) begin
            // Enough equal samples, take the new level
            pressed_disp <= level;
            pressed      <= level;   // Only the rising flip is a press
            diff_cnt     <= '0;
          end else begin
            diff_cnt <= diff_cnt + 1'b1;
          end
        end else begin
          diff_cnt <= '0;   // Bounce back, start over
        end
      end
    end
  end

  // A held button must give one press only
  press_is_pulse: assert property (@(posedge clk) disable iff (reset)
    pressed |=> !pressed)
    else $error("pressed high for two cycles");

endmodule

/* hw/key_event_arbiter.sv */
`include "gb_debug_defines.svh"

module key_event_arbiter (
  input  logic                       clk,
  input  logic                       reset,
  input  gb_debug_pkg::button_mask_t pressed,
  output logic                       event_req,
  output gb_debug_pkg::button_idx_t  event_code,
  input  logic                       event_ack
);

  gb_debug_pkg::arb_state_e   state;
  gb_debug_pkg::button_mask_t pending;     // Presses not yet sent
  gb_debug_pkg::button_mask_t cand;        // Pending plus this cycle's presses
  gb_debug_pkg::button_mask_t load_mask;   // Bit taken by this load
  gb_debug_pkg::button_idx_t  sel;
  logic                       load;

  // Lowest index wins
  function automatic gb_debug_pkg::button_idx_t lowest_set(
    input gb_debug_pkg::button_mask_t m);
    lowest_set = '0;
    for (int i = `GB_N_BUTTONS - 1; i >= 0; i--) begin
      if (m[i]) lowest_set = gb_debug_pkg::button_idx_t'(i);
    end
  endfunction

  assign cand = pending | pressed;
  assign sel  = lowest_set(cand);
  // New event only from idle or once the last ack has dropped
  assign load = (|cand) && ((state == gb_debug_pkg::ARB_IDLE) ||
                ((state == gb_debug_pkg::ARB_WAIT_ACK_LOW) && !event_ack));
  assign load_mask = load ? (gb_debug_pkg::button_mask_t'(1) << sel) : '0;

  ////////////////////////////////////////////////////////////////////////////
  // Four-phase req/ack sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= gb_debug_pkg::ARB_IDLE;
      pending    <= '0;
      event_req  <= 1'b0;
      event_code <= '0;
    end else begin
      pending <= cand & ~load_mask;   // Repeat press merges into its bit
      if (load) begin
        event_code <= sel;   // Held until the next load
      end
      case (state)
        gb_debug_pkg::ARB_IDLE: begin
          if (load) begin
            event_req <= 1'b1;
            state     <= gb_debug_pkg::ARB_REQ;
          end
        end
        gb_debug_pkg::ARB_REQ: begin
          if (event_ack) begin
            event_req <= 1'b0;
            state     <= gb_debug_pkg::ARB_WAIT_ACK_LOW;
          end
        end
        gb_debug_pkg::ARB_WAIT_ACK_LOW: begin
          if (!event_ack) begin
            event_req <= load;   // Back to back if more is pending
            state     <= load ? gb_debug_pkg::ARB_REQ : gb_debug_pkg::ARB_IDLE;
          end
        end
        default: state <= gb_debug_pkg::ARB_IDLE;
      endcase
    end
  end

  // Controller samples the code any time during req
  code_stable: assert property (@(posedge clk) disable iff (reset)
    event_req && $past(event_req) |-> $stable(event_code))
    else $error("event_code changed while event_req high");

endmodule

/* hw/debug_controller.sv */
module debug_controller (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      event_req,
  input  gb_debug_pkg::button_idx_t event_code,
  output logic                      event_ack,
  input  gb_debug_pkg::addr_t       cpu_pc,
  output logic                      cpu_run,
  output logic                      debug_halt,
  output gb_debug_pkg::addr_t       bp_addr,
  output logic                      bp_enable
);

  gb_debug_pkg::ctrl_state_e state;
  logic                      cmd_valid;   // New command, not yet acked
  logic                      run_first;   // First cycle of a continue
  logic                      bp_hit;

  assign cmd_valid = event_req && !event_ack;

  // No hit on the first run cycle, so continue leaves a breakpoint
  assign bp_hit = (state == gb_debug_pkg::CTRL_RUN) && !run_first &&
                  bp_enable && (cpu_pc == bp_addr);

  // Hit stops the CPU in the same cycle, pc stays on the breakpoint
  assign cpu_run = (state == gb_debug_pkg::CTRL_STEP) ||
                   ((state == gb_debug_pkg::CTRL_RUN) && !bp_hit);
  assign debug_halt = !cpu_run;

  ////////////////////////////////////////////////////////////////////////////
  // Command handling and run control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= gb_debug_pkg::CTRL_HALTED;
      event_ack <= 1'b0;
      run_first <= 1'b0;
      bp_addr   <= '0;
      bp_enable <= 1'b0;
    end else begin
      // Ack one cycle after req, drop once req is gone
      if (cmd_valid) begin
        event_ack <= 1'b1;
      end else if (!event_req) begin
        event_ack <= 1'b0;
      end
      run_first <= 1'b0;
      // Breakpoint commands act in any state
      if (cmd_valid && (event_code == gb_debug_pkg::EV_BP_SET)) begin
        bp_addr <= cpu_pc;
      end
      if (cmd_valid && (event_code == gb_debug_pkg::EV_BP_TOGGLE)) begin
        bp_enable <= !bp_enable;
      end
      case (state)
        gb_debug_pkg::CTRL_HALTED: begin
          if (cmd_valid) begin
            case (event_code)
              gb_debug_pkg::EV_STEP: state <= gb_debug_pkg::CTRL_STEP;
              gb_debug_pkg::EV_CONTINUE: begin
                state     <= gb_debug_pkg::CTRL_RUN;
                run_first <= 1'b1;
              end
              default: state <= gb_debug_pkg::CTRL_ACK;   // Bp only, stay halted
            endcase
          end
        end
        gb_debug_pkg::CTRL_STEP: state <= gb_debug_pkg::CTRL_ACK;   // One cycle only
        gb_debug_pkg::CTRL_RUN: begin
          if (cmd_valid && (event_code == gb_debug_pkg::EV_STEP)) begin
            state <= gb_debug_pkg::CTRL_STEP;   // Last cycle, then halt
          end else if (cmd_valid && (event_code == gb_debug_pkg::EV_CONTINUE)) begin
            run_first <= 1'b1;
          end else if (bp_hit) begin
            state <= gb_debug_pkg::CTRL_HALTED;
          end
        end
        gb_debug_pkg::CTRL_ACK: begin
          if (!event_req) state <= gb_debug_pkg::CTRL_HALTED;
        end
        default: state <= gb_debug_pkg::CTRL_HALTED;
      endcase
    end
  end

  // Four-phase rule, controller side
  ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(event_ack) |-> event_req)
    else $error("event_ack rose without event_req");

endmodule

/* hw/debugger_text.sv */
`include "gb_debug_defines.svh"

module debugger_text (
  input  logic                clk,
  input  logic                reset,
  input  gb_debug_pkg::col_t  x,          // Screen cursor column
  input  gb_debug_pkg::row_t  y,          // Screen cursor row
  input  gb_debug_pkg::addr_t reg_pc,
  input  gb_debug_pkg::addr_t bp_addr,
  input  logic                bp_enable,
  input  logic                debug_halt,
  output gb_debug_pkg::char_t chr         // One cycle after x, y
);

  localparam gb_debug_pkg::char_t CH_SPACE = 7'h20;

  gb_debug_pkg::char_t next_chr;
  logic                in_range;

  // Drop the top bit of an 8-bit literal
  function automatic gb_debug_pkg::char_t ascii(input logic [7:0] c);
    ascii = c[6:0];
  endfunction

  // Upper case hex digit
  function automatic gb_debug_pkg::char_t hex_digit(input logic [3:0] n);
    if (n < 4'd10) begin
      hex_digit = 7'h30 + {3'b000, n};   // '0'..'9'
    end else begin
      hex_digit = 7'h37 + {3'b000, n};   // 'A'..'F'
    end
  endfunction

  assign in_range = (x < 7'(`GB_TEXT_COLS)) && (y < 5'(`GB_TEXT_ROWS));

  ////////////////////////////////////////////////////////////////////////////
  // Row 0 status line   "PC=xxxx BP=xxxx E H"
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    next_chr = CH_SPACE;   // Blank everywhere else
    if (in_range && (y == '0)) begin
      case (x)
        7'd0:  next_chr = ascii("P");
        7'd1:  next_chr = ascii("C");
        7'd2:  next_chr = ascii("=");
        7'd3:  next_chr = hex_digit(reg_pc[15:12]);
        7'd4:  next_chr = hex_digit(reg_pc[11:8]);
        7'd5:  next_chr = hex_digit(reg_pc[7:4]);
        7'd6:  next_chr = hex_digit(reg_pc[3:0]);
        7'd8:  next_chr = ascii("B");
        7'd9:  next_chr = ascii("P");
        7'd10: next_chr = ascii("=");
        7'd11: next_chr = hex_digit(bp_addr[15:12]);
        7'd12: next_chr = hex_digit(bp_addr[11:8]);
        7'd13: next_chr = hex_digit(bp_addr[7:4]);
        7'd14: next_chr = hex_digit(bp_addr[3:0]);
        7'd16: next_chr = bp_enable ? ascii("E") : ascii("-");
        7'd18: next_chr = debug_halt ? ascii("H") : ascii("R");
        default: next_chr = CH_SPACE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      chr <= CH_SPACE;
    end else begin
      chr <= next_chr;
    end
  end

endmodule

/* hw/gb_debug_panel.sv */
`include "gb_debug_defines.svh"

module gb_debug_panel (
  input  logic                       clk,
  input  logic                       reset,
  input  gb_debug_pkg::button_mask_t button_raw,   // Raw push buttons
  output gb_debug_pkg::button_mask_t led,          // Debounced levels
  input  gb_debug_pkg::addr_t        cpu_pc,
  output logic                       cpu_run,
  output logic                       debug_halt,
  input  gb_debug_pkg::col_t         text_x,
  input  gb_debug_pkg::row_t         text_y,
  output gb_debug_pkg::char_t        text_chr
);

  gb_debug_pkg::button_mask_t sync_level;
  gb_debug_pkg::button_mask_t pressed;      // Press pulses, one per button
  gb_debug_pkg::button_idx_t  event_code;
  gb_debug_pkg::addr_t        bp_addr;
  logic                       sample_tick;
  logic                       event_req;
  logic                       event_ack;
  logic                       bp_enable;

  button_sync u_button_sync (
    .clk(clk), .reset(reset), .button_raw(button_raw),
    .sync_level(sync_level), .sample_tick(sample_tick)
  );

  // One debouncer per button
  for (genvar i = 0; i < `GB_N_BUTTONS; i++) begin : g_button
    button u_button (
      .clk(clk), .reset(reset), .level(sync_level[i]), .sample_tick(sample_tick),
      .pressed(pressed[i]), .pressed_disp(led[i])
    );
  end

  key_event_arbiter u_key_event_arbiter (
    .clk(clk), .reset(reset), .pressed(pressed),
    .event_req(event_req), .event_code(event_code), .event_ack(event_ack)
  );

  debug_controller u_debug_controller (
    .clk(clk), .reset(reset),
    .event_req(event_req), .event_code(event_code), .event_ack(event_ack),
    .cpu_pc(cpu_pc), .cpu_run(cpu_run), .debug_halt(debug_halt),
    .bp_addr(bp_addr), .bp_enable(bp_enable)
  );

  // Status row of the overlay
  debugger_text u_debugger_text (
    .clk(clk), .reset(reset), .x(text_x), .y(text_y),
    .reg_pc(cpu_pc), .bp_addr(bp_addr), .bp_enable(bp_enable),
    .debug_halt(debug_halt), .chr(text_chr)
  );

endmodule

/* testbench/tb_gb_debug_panel.sv */
module tb_gb_debug_panel;

  localparam int HOLD_CYCLES  = 40;   // Button held, then released, this long
  localparam int QUIET_CYCLES = 60;   // Settled window after a press

  logic                       clk;
  logic                       reset;
  gb_debug_pkg::button_mask_t button_raw;
  gb_debug_pkg::button_mask_t led;
  gb_debug_pkg::addr_t        cpu_pc = '0;
  logic                       cpu_run;
  logic                       debug_halt;
  gb_debug_pkg::col_t         text_x;
  gb_debug_pkg::row_t         text_y;
  gb_debug_pkg::char_t        text_chr;

  logic                pc_set;       // CPU model load strobe
  gb_debug_pkg::addr_t pc_set_val;

  string       test_name[$];
  string       test_op[$];
  logic [15:0] test_arg[$];
  logic [15:0] test_exp[$];

  int                         run_cnt = 0;   // Cycles with cpu_run high
  int                         run_start;
  int                         last_runs;     // Run cycles of the last press
  gb_debug_pkg::button_mask_t led_hold;      // led at the end of the hold
  int                         cycle_cnt = 0;
  int                         cycle_limit;
  int                         errors;
  int                         passes;
  logic                       loaded;

  gb_debug_panel u_gb_debug_panel (
    .clk(clk), .reset(reset), .button_raw(button_raw), .led(led),
    .cpu_pc(cpu_pc), .cpu_run(cpu_run), .debug_halt(debug_halt),
    .text_x(text_x), .text_y(text_y), .text_chr(text_chr)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // CPU model and watchdog
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (reset) cpu_pc <= '0;
    else if (pc_set) cpu_pc <= pc_set_val;   // Only while halted
    else if (cpu_run) cpu_pc <= cpu_pc + 1'b1;   // One instruction per run cycle
  end

  always @(posedge clk) begin
    if (!reset && cpu_run) run_cnt <= run_cnt + 1;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if ((cycle_limit != 0) && (cycle_cnt > cycle_limit)) begin
      $display("Timeout: the DUT did not settle within %0d cycles", cycle_limit);
      $display("Test failures found");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_stimulus(output logic ok);
    int          fd;
    int          got;
    string       line;
    string       name;
    string       op;
    logic [15:0] arg;
    logic [15:0] exp_val;
    fd = $fopen("testbench/gb_debug_panel_stimulus.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      while (!$feof(fd)) begin
        line = "";
        got = $fgets(line, fd);
        // Skip comments and blank lines
        if ((got > 0) && (line.len() > 1) && (line.getc(0) != "#")) begin
          if ($sscanf(line, "%s %s %h %h", name, op, arg, exp_val) == 4) begin
            test_name.push_back(name);
            test_op.push_back(op);
            test_arg.push_back(arg);
            test_exp.push_back(exp_val);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // One result line per test
  task automatic report(input string name, input logic [15:0] expected,
                        input logic [15:0] actual);
    assert (actual === expected) begin
      passes++;
      $display("%-12s ok", name);
    end else begin
      errors++;
      $display("error %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic set_pc(input gb_debug_pkg::addr_t value);
    @(posedge clk);
    pc_set_val <= value;
    pc_set     <= 1'b1;
    @(posedge clk);
    pc_set     <= 1'b0;
  endtask

  task automatic press_buttons(input gb_debug_pkg::button_mask_t mask);
    int jitter;
    jitter = $urandom % 8;   // Vary the phase against the sample tick
    repeat (jitter) @(posedge clk);
    @(negedge clk);
    run_start = run_cnt;
    @(posedge clk);
    button_raw <= mask;
    repeat (HOLD_CYCLES) @(posedge clk);
    @(negedge clk);
    led_hold = led;   // Debounced level while held
    @(posedge clk);
    button_raw <= '0;
    repeat (HOLD_CYCLES) @(posedge clk);
  endtask

  // Two-cycle bounce, shorter than the debounce window
  task automatic glitch_buttons(input gb_debug_pkg::button_mask_t mask);
    @(negedge clk);
    run_start = run_cnt;
    @(posedge clk);
    button_raw <= mask;
    repeat (2) @(posedge clk);
    button_raw <= '0;
  endtask

  // Halted, released and quiet for a full window
  task automatic wait_settled();
    int quiet;
    quiet = 0;
    while (quiet < QUIET_CYCLES) begin
      @(negedge clk);
      if (debug_halt && !cpu_run && (led == '0)) quiet++;
      else quiet = 0;
    end
    last_runs = run_cnt - run_start;
  endtask

  task automatic watch_run(output logic held);
    int high_cnt;
    high_cnt = 0;
    repeat (QUIET_CYCLES) begin
      @(negedge clk);
      if (cpu_run) high_cnt++;
    end
    held = (high_cnt == QUIET_CYCLES);
  endtask

  task automatic read_text(input gb_debug_pkg::col_t col, output gb_debug_pkg::char_t c);
    @(posedge clk);
    text_x <= col;
    text_y <= '0;
    repeat (2) @(negedge clk);   // chr is registered
    c = text_chr;
  endtask

  task automatic run_test(input string name, input string op,
                          input logic [15:0] arg, input logic [15:0] exp_val);
    gb_debug_pkg::char_t chr_seen;
    logic                held;
    if (op == "idle") begin
      @(negedge clk);
      report(name, exp_val, 16'(debug_halt && !cpu_run && (led == '0)));
    end else if (op == "setpc") begin
      set_pc(arg);
      @(posedge clk);   // A halted CPU keeps the loaded pc
      @(negedge clk);
      report(name, exp_val, cpu_pc);
    end else if (op == "press") begin
      press_buttons(arg[3:0]);
      wait_settled();
      report(name, exp_val, cpu_pc);
    end else if (op == "halt") begin
      press_buttons(arg[3:0]);
      @(negedge clk);   // Step press ends the run
      report(name, exp_val, 16'(debug_halt));
      wait_settled();
    end else if (op == "go") begin
      press_buttons(arg[3:0]);
      watch_run(held);   // Still running, no breakpoint ahead
      report(name, exp_val, 16'(held));
    end else if (op == "glitch") begin
      glitch_buttons(arg[3:0]);
      wait_settled();
      report(name, exp_val, 16'(last_runs));
    end else if (op == "runs") begin
      report(name, exp_val, 16'(last_runs));
    end else if (op == "led") begin
      report(name, exp_val, 16'(led_hold));
    end else if (op == "pcgt") begin
      @(negedge clk);
      report(name, exp_val, 16'(cpu_pc > arg));
    end else if (op == "text") begin
      read_text(arg[6:0], chr_seen);
      report(name, exp_val, 16'(chr_seen));
    end else begin
      errors++;
      $display("Test %s uses an unknown operation %s", name, op);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    reset       = 1'b1;
    button_raw  = '0;
    text_x      = '0;
    text_y      = '0;
    pc_set      = 1'b0;
    pc_set_val  = '0;
    errors      = 0;
    passes      = 0;
    cycle_limit = 0;
    void'($urandom(32'h73358222));
    load_stimulus(loaded);
    if (!loaded) begin
      errors++;
      $display("The stimulus file could not be opened");
    end else begin
      cycle_limit = test_name.size() * 200 + 500;   // Armed once lines are known
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      for (int i = 0; i < test_name.size(); i++) begin
        run_test(test_name[i], test_op[i], test_arg[i], test_exp[i]);
      end
    end
    $display("%0d passed, %0d failed", passes, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* gb_debug_panel.f */
+incdir+include
hw/gb_debug_pkg.sv
hw/button_sync.sv
hw/button.sv
hw/key_event_arbiter.sv
hw/debug_controller.sv
hw/debugger_text.sv
hw/gb_debug_panel.sv
testbench/tb_gb_debug_panel.sv

/* Bender.yml */
package:
  name: gb_debug_panel

sources:
  # Design, in compile order
  - include_dirs:
      - include
    files:
      - hw/gb_debug_pkg.sv
      - hw/button_sync.sv
      - hw/button.sv
      - hw/key_event_arbiter.sv
      - hw/debug_controller.sv
      - hw/debugger_text.sv
      - hw/gb_debug_panel.sv

  # Testbench
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/tb_gb_debug_panel.sv

/* testbench/gb_debug_panel_stimulus.txt */
# name  operation  argument  expected; all numbers in hex
# press/halt/go/glitch take a button mask, text takes a row-0 column
reset_idle   idle    0     1
reset_en     text    10    2d
reset_halt   text    12    48
step_setpc   setpc   0100  0100
step_pc      press   1     0101
step_runs    runs    0     1
step_led     led     0     1
bp_setpc     setpc   0104  0104
bp_step      press   1     0105
bp_set       press   8     0105
bp_enable    press   4     0105
bp_rewind    setpc   0100  0100
bp_cont      press   2     0105
bp_runs      runs    0     5
bp_text_hi   text    0c    31
bp_text_lo   text    0e    35
bp_text_en   text    10    45
cont_go      go      2     1
cont_past    pcgt    0105  1
cont_stop    halt    1     1
glitch_runs  glitch  1     0
dual_setpc   setpc   0200  0200
dual_press   press   c     0200
dual_led     led     0     c
dual_bp      text    0c    32
dual_en      text    10    2d
